// ==== source/aes_pkg.sv ====
package aes_pkg;

  localparam logic [3:0] AES_ROUNDS = 4'd10;   // AES-128 always runs ten rounds.

  // Wishbone word addresses. Word 0 of a block is its most significant word.
  localparam logic [3:0] ADR_KEY0   = 4'd0;
  localparam logic [3:0] ADR_KEY1   = 4'd1;
  localparam logic [3:0] ADR_KEY2   = 4'd2;
  localparam logic [3:0] ADR_KEY3   = 4'd3;
  localparam logic [3:0] ADR_DATA0  = 4'd4;
  localparam logic [3:0] ADR_DATA1  = 4'd5;
  localparam logic [3:0] ADR_DATA2  = 4'd6;
  localparam logic [3:0] ADR_DATA3  = 4'd7;
  localparam logic [3:0] ADR_CTRL   = 4'd8;
  localparam logic [3:0] ADR_STATUS = 4'd9;
  localparam logic [3:0] ADR_RES0   = 4'd12;
  localparam logic [3:0] ADR_RES1   = 4'd13;
  localparam logic [3:0] ADR_RES2   = 4'd14;
  localparam logic [3:0] ADR_RES3   = 4'd15;

  // Sequencer FSM states.
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_PRERUN = 2'd1;   // Forward key schedule before decryption.
  localparam logic [1:0] ST_ROUND  = 2'd2;
  localparam logic [1:0] ST_DONE   = 2'd3;

  typedef logic [127:0] aes_block_t;
  typedef logic [31:0]  aes_word_t;

  // The state seen as bytes for SubBytes and ShiftRows, or as columns for MixColumns.
  // Index 0 sits at the most significant end in both views, as in FIPS-197.
  typedef union packed {
    logic [0:15][7:0] b;
    logic [0:3][31:0] col;
  } aes_state_u;

  typedef struct packed {
    logic start;     // One cycle pulse on a CTRL write with bit 0 set.
    logic decrypt;   // CTRL bit 1.
  } aes_cmd_t;

  typedef struct packed {
    logic       load;      // Capture the text, or the key when decrypting.
    logic       run;       // Advance one step.
    logic       last;      // Final round, MixColumns is skipped.
    logic       reverse;   // Key schedule steps backward.
    logic       decrypt;
    logic [3:0] round;     // Index of the higher key in the current schedule step.
  } aes_seq_t;

  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    logic [3:0] adr;
    aes_word_t dat;
  } aes_wb_req_t;

  typedef struct packed {
    logic      ack;
    aes_word_t dat;
  } aes_wb_rsp_t;

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);   // Multiply by x modulo 0x11b.
  endfunction

  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      p = p ^ (b[i] ? x : 8'h00);   // Add the shifted multiplicand for each set bit.
      x = xtime(x);
    end
    return p;
  endfunction

  // Multiplicative inverse as a^254, which also maps zero to zero.
  function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] r;
    logic [7:0] p;
    r = 8'h01;
    p = a;
    for (int i = 1; i < 8; i++) begin
      p = gf_mul(p, p);   // p is a^(2^i).
      r = gf_mul(r, p);
    end
    return r;
  endfunction

  function automatic logic [7:0] sbox(input logic [7:0] a);
    logic [7:0] x;
    x = gf_inv(a);
    // The affine map, written as rotations of the inverse.
    return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]} ^ {x[3:0], x[7:4]} ^ 8'h63;
  endfunction

  function automatic logic [7:0] inv_sbox(input logic [7:0] a);
    logic [7:0] y;
    y = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;   // Undo the affine map.
    return gf_inv(y);
  endfunction

  function automatic logic [7:0] rcon(input logic [3:0] i);
    case (i)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;   // Steps outside the schedule produce a discarded key.
    endcase
  endfunction

  function automatic aes_word_t sub_word(input aes_word_t w);
    return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
  endfunction

endpackage

// ==== source/aes_key_expand.sv ====
`timescale 1ns/100ps

// Round key generator for AES-128.
// Each step moves one key along the schedule, forward or backward.
module aes_key_expand (
  input  logic                clk,
  input  logic                arst_n,
  input  aes_pkg::aes_seq_t   seq,
  input  aes_pkg::aes_block_t key,
  output aes_pkg::aes_block_t round_key
);

  aes_pkg::aes_block_t key_q;   // Holds the key that the datapath uses this cycle.
  logic [0:3][31:0]    cur_w;
  logic [0:3][31:0]    fwd_w;
  logic [0:3][31:0]    rev_w;
  logic [31:0]         fwd_t;
  logic [31:0]         rev_t;
  logic [7:0]          rc;

  assign cur_w = key_q;
  assign rc    = aes_pkg::rcon(seq.round);

  // Forward step, w[i] = w[i-4] ^ w[i-1] with the g() function on the first word.
  assign fwd_t    = aes_pkg::sub_word({cur_w[3][23:0], cur_w[3][31:24]}) ^ {rc, 24'h000000};
  assign fwd_w[0] = cur_w[0] ^ fwd_t;
  assign fwd_w[1] = cur_w[1] ^ fwd_w[0];
  assign fwd_w[2] = cur_w[2] ^ fwd_w[1];
  assign fwd_w[3] = cur_w[3] ^ fwd_w[2];

  // Reverse step.
  // The last three words come back by XOR of neighbours in the newer key.
  assign rev_w[3] = cur_w[3] ^ cur_w[2];
  assign rev_w[2] = cur_w[2] ^ cur_w[1];
  assign rev_w[1] = cur_w[1] ^ cur_w[0];
  // The first word needs g() of the recovered last word.
  assign rev_t    = aes_pkg::sub_word({rev_w[3][23:0], rev_w[3][31:24]}) ^ {rc, 24'h000000};
  assign rev_w[0] = cur_w[0] ^ rev_t;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      key_q <= '0;
    end else if (seq.reverse) begin
      key_q <= rev_w;   // Round key r becomes round key r - 1.
    end else if (seq.run) begin
      key_q <= fwd_w;   // Round key r - 1 becomes round key r.
    end else begin
      // Between operations the register follows the cipher key.
      // Round key 0 is then ready in the cycle that the start arrives.
      key_q <= key;
    end
  end

  assign round_key = key_q;

endmodule

// ==== source/aes_round.sv ====
`timescale 1ns/100ps

// AES state register with one forward or inverse round per cycle.
module aes_round (
  input  logic                clk,
  input  logic                arst_n,
  input  aes_pkg::aes_seq_t   seq,
  input  aes_pkg::aes_block_t text,
  input  aes_pkg::aes_block_t round_key,
  output aes_pkg::aes_block_t result
);

  aes_pkg::aes_state_u state_q;
  aes_pkg::aes_state_u enc_sr;    // SubBytes and ShiftRows.
  aes_pkg::aes_state_u enc_mix;   // Plus MixColumns.
  aes_pkg::aes_state_u dec_sr;    // InvShiftRows and InvSubBytes.
  aes_pkg::aes_state_u dec_ark;   // Plus AddRoundKey.
  aes_pkg::aes_state_u dec_mix;   // Plus InvMixColumns.

  function automatic logic [31:0] mix_col(input logic [31:0] c);
    logic [7:0] a0, a1, a2, a3;
    {a0, a1, a2, a3} = c;
    return {aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3,
            aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3)};
  endfunction

  // Inverse matrix rows are rotations of {0e, 0b, 0d, 09}.
  function automatic logic [31:0] inv_mix_col(input logic [31:0] c);
    logic [0:3][7:0] a;
    logic [0:3][7:0] m;
    a = c;
    for (int r = 0; r < 4; r++) begin
      m[r] = aes_pkg::gf_mul(a[r], 8'h0e) ^
             aes_pkg::gf_mul(a[(r + 1) % 4], 8'h0b) ^
             aes_pkg::gf_mul(a[(r + 2) % 4], 8'h0d) ^
             aes_pkg::gf_mul(a[(r + 3) % 4], 8'h09);
    end
    return m;
  endfunction

  always_comb begin
    // Byte n sits in row n % 4 of column n / 4.
    // ShiftRows rotates row r left by r columns, the inverse rotates it right.
    for (int n = 0; n < 16; n++) begin
      enc_sr.b[n] = aes_pkg::sbox(state_q.b[4 * ((n / 4 + n % 4) % 4) + n % 4]);
      dec_sr.b[n] = aes_pkg::inv_sbox(state_q.b[4 * ((n / 4 + 4 - n % 4) % 4) + n % 4]);
    end
    dec_ark = dec_sr ^ round_key;   // The inverse round adds the key before unmixing.
    for (int c = 0; c < 4; c++) begin
      enc_mix.col[c] = mix_col(enc_sr.col[c]);
      dec_mix.col[c] = inv_mix_col(dec_ark.col[c]);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= '0;
    end else if (seq.load) begin
      state_q <= text ^ round_key;   // Initial AddRoundKey.
    end else if (seq.run && !seq.decrypt) begin
      state_q <= (seq.last ? enc_sr : enc_mix) ^ round_key;
    end else if (seq.run && seq.reverse) begin
      // Run without reverse during decryption is the key pre-run, so the state holds.
      state_q <= seq.last ? dec_ark : dec_mix;
    end
  end

  assign result = state_q;

endmodule

// ==== source/aes_ctrl.sv ====
`timescale 1ns/100ps

// Sequencer for one block.
// Encryption takes 11 cycles from start to done, decryption 22.
module aes_ctrl (
  input  logic              clk,
  input  logic              arst_n,
  input  aes_pkg::aes_cmd_t cmd,
  output aes_pkg::aes_seq_t seq,
  output logic              busy,
  output logic              done
);

  logic [1:0] state_q;
  logic [3:0] cnt_q;   // Counts up in encryption and the pre-run, down in inverse rounds.
  logic       dec_q;   // Direction latched at start.

  always_comb begin
    seq         = '0;
    seq.decrypt = dec_q;
    case (state_q)
      aes_pkg::ST_IDLE: begin
        // Cycle 0 runs straight from the start pulse.
        seq.decrypt = cmd.decrypt;
        seq.load    = cmd.start;
        seq.run     = cmd.start & ~cmd.decrypt;   // Encryption also steps to round key 1.
        seq.round   = {3'b000, cmd.start};
      end
      aes_pkg::ST_PRERUN: begin
        seq.run   = 1'b1;    // Only the key expander moves.
        seq.round = cnt_q;
      end
      aes_pkg::ST_ROUND: begin
        if (dec_q) begin
          seq.reverse = 1'b1;
          seq.load    = (cnt_q == aes_pkg::AES_ROUNDS);   // Text XOR round key 10.
          seq.run     = (cnt_q != aes_pkg::AES_ROUNDS);
          seq.last    = (cnt_q == 4'd0);
          seq.round   = cnt_q;
        end else begin
          seq.run   = 1'b1;
          seq.last  = (cnt_q == aes_pkg::AES_ROUNDS);
          seq.round = cnt_q + 4'd1;   // The key expander works one key ahead.
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= aes_pkg::ST_IDLE;
      cnt_q   <= 4'd0;
      dec_q   <= 1'b0;
    end else begin
      case (state_q)
        aes_pkg::ST_IDLE: begin
          if (cmd.start) begin   // A start in any other state is dropped.
            dec_q   <= cmd.decrypt;
            cnt_q   <= 4'd1;
            state_q <= cmd.decrypt ? aes_pkg::ST_PRERUN : aes_pkg::ST_ROUND;
          end
        end
        aes_pkg::ST_PRERUN: begin
          if (cnt_q == aes_pkg::AES_ROUNDS) begin
            state_q <= aes_pkg::ST_ROUND;   // Counter stays at 10 for the inverse start.
          end else begin
            cnt_q <= cnt_q + 4'd1;
          end
        end
        aes_pkg::ST_ROUND: begin
          if (dec_q ? (cnt_q == 4'd0) : (cnt_q == aes_pkg::AES_ROUNDS)) begin
            state_q <= aes_pkg::ST_DONE;
          end else begin
            cnt_q <= dec_q ? cnt_q - 4'd1 : cnt_q + 4'd1;
          end
        end
        default: state_q <= aes_pkg::ST_IDLE;
      endcase
    end
  end

  assign busy = (state_q != aes_pkg::ST_IDLE);   // Includes the done cycle.
  assign done = (state_q == aes_pkg::ST_DONE);

endmodule

// ==== source/aes_wb_regs.sv ====
`timescale 1ns/100ps

// Wishbone classic slave holding the key, data, control, status and result words.
module aes_wb_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  aes_pkg::aes_wb_req_t wb_req,
  output aes_pkg::aes_wb_rsp_t wb_rsp,
  output aes_pkg::aes_cmd_t    cmd,
  input  logic                 busy,
  input  logic                 done,
  output aes_pkg::aes_block_t  key,
  output aes_pkg::aes_block_t  text,
  input  aes_pkg::aes_block_t  result
);

  logic [0:3][31:0]  key_w;    // Word 0 is the most significant.
  logic [0:3][31:0]  text_w;
  logic [0:3][31:0]  res_w;
  logic              decrypt_q;
  logic              start_q;
  logic              done_sticky_q;
  logic              ack_q;
  aes_pkg::aes_word_t dat_q;
  aes_pkg::aes_word_t rd_dat;
  logic              req;
  logic              wr;

  // A new request is one not yet acknowledged, so ack never lasts two cycles.
  assign req = wb_req.cyc & wb_req.stb & ~ack_q;
  assign wr  = req & wb_req.we;

  always_comb begin
    rd_dat = '0;   // Unmapped words read as zero.
    case (wb_req.adr)
      aes_pkg::ADR_KEY0, aes_pkg::ADR_KEY1,
      aes_pkg::ADR_KEY2, aes_pkg::ADR_KEY3:   rd_dat = key_w[wb_req.adr[1:0]];
      aes_pkg::ADR_DATA0, aes_pkg::ADR_DATA1,
      aes_pkg::ADR_DATA2, aes_pkg::ADR_DATA3: rd_dat = text_w[wb_req.adr[1:0]];
      aes_pkg::ADR_CTRL:   rd_dat = {30'd0, decrypt_q, 1'b0};   // Start reads back as zero.
      aes_pkg::ADR_STATUS: rd_dat = {30'd0, done_sticky_q, busy};
      aes_pkg::ADR_RES0, aes_pkg::ADR_RES1,
      aes_pkg::ADR_RES2, aes_pkg::ADR_RES3:   rd_dat = res_w[wb_req.adr[1:0]];
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      key_w         <= '0;
      text_w        <= '0;
      res_w         <= '0;
      decrypt_q     <= 1'b0;
      start_q       <= 1'b0;
      done_sticky_q <= 1'b0;
      ack_q         <= 1'b0;
      dat_q         <= '0;
    end else begin
      ack_q   <= req;
      start_q <= wr && (wb_req.adr == aes_pkg::ADR_CTRL) && wb_req.dat[0];
      if (req) begin
        dat_q <= rd_dat;   // Read data goes out with the ack.
      end
      if (wr) begin
        case (wb_req.adr)   // Status, result and unmapped words ignore writes.
          aes_pkg::ADR_KEY0, aes_pkg::ADR_KEY1,
          aes_pkg::ADR_KEY2, aes_pkg::ADR_KEY3:   key_w[wb_req.adr[1:0]] <= wb_req.dat;
          aes_pkg::ADR_DATA0, aes_pkg::ADR_DATA1,
          aes_pkg::ADR_DATA2, aes_pkg::ADR_DATA3: text_w[wb_req.adr[1:0]] <= wb_req.dat;
          aes_pkg::ADR_CTRL:                      decrypt_q <= wb_req.dat[1];
          default: ;
        endcase
      end
      if (done) begin
        res_w         <= result;   // RES is stable from the cycle after done.
        done_sticky_q <= 1'b1;     // Wins over a start that the busy core drops.
      end else if (start_q) begin
        done_sticky_q <= 1'b0;
      end
    end
  end

  assign cmd.start   = start_q;
  assign cmd.decrypt = decrypt_q;
  assign key         = key_w;
  assign text        = text_w;
  assign wb_rsp.ack  = ack_q;
  assign wb_rsp.dat  = dat_q;

endmodule

// ==== source/aes_core_top.sv ====
`timescale 1ns/100ps

// AES-128 core with a Wishbone register port.
module aes_core_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  aes_pkg::aes_wb_req_t wb_req,
  output aes_pkg::aes_wb_rsp_t wb_rsp
);

  aes_pkg::aes_cmd_t   cmd;         // Start and direction from CTRL.
  aes_pkg::aes_seq_t   seq;         // Shared by the key expander and the datapath.
  logic                busy;
  logic                done;
  aes_pkg::aes_block_t key;
  aes_pkg::aes_block_t text;
  aes_pkg::aes_block_t round_key;
  aes_pkg::aes_block_t result;

  // Register block.
  aes_wb_regs u_aes_wb_regs (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .cmd    (cmd),
    .busy   (busy),
    .done   (done),
    .key    (key),
    .text   (text),
    .result (result)
  );

  // Sequencer.
  aes_ctrl u_aes_ctrl (
    .clk    (clk),
    .arst_n (arst_n),
    .cmd    (cmd),
    .seq    (seq),
    .busy   (busy),
    .done   (done)
  );

  // Key schedule, one round key per cycle.
  aes_key_expand u_aes_key_expand (
    .clk       (clk),
    .arst_n    (arst_n),
    .seq       (seq),
    .key       (key),
    .round_key (round_key)
  );

  // Round datapath.
  aes_round u_aes_round (
    .clk       (clk),
    .arst_n    (arst_n),
    .seq       (seq),
    .text      (text),
    .round_key (round_key),
    .result    (result)
  );

endmodule

// ==== dv/aes_core_properties.sv ====
`timescale 1ns/100ps

// Wishbone and sequencer timing rules, bound into the core top level.
module aes_core_properties (
  input logic                 clk,
  input logic                 arst_n,
  input aes_pkg::aes_wb_req_t wb_req,
  input aes_pkg::aes_wb_rsp_t wb_rsp,
  input logic                 busy,
  input logic                 done
);

  ack_single: assert property (@(posedge clk) disable iff (!arst_n)
    wb_rsp.ack |=> !wb_rsp.ack)   // The ack is a one cycle pulse.
    else $error("ack stayed high for two cycles");

  // A request not yet answered gets its ack on the next clock.
  ack_latency: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
    else $error("ack did not follow the request by one cycle");

  done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    done |=> !done)
    else $error("done lasted more than one cycle");

  busy_at_release: assert property (@(posedge clk)
    $rose(arst_n) |-> !busy)   // The sequencer leaves reset idle.
    else $error("busy was high when reset was released");

endmodule

bind aes_core_top aes_core_properties u_aes_core_properties (
  .clk    (clk),
  .arst_n (arst_n),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp),
  .busy   (busy),
  .done   (done)
);

// ==== dv/aes_core_tb.sv ====
`timescale 1ns/100ps

// Testbench for the AES-128 core, driven through its Wishbone port.
module aes_core_tb;

  typedef struct packed {
    aes_pkg::aes_block_t key;
    aes_pkg::aes_block_t pt;
    aes_pkg::aes_block_t ct;
  } kat_t;

  // Known-answer rows from FIPS-197 B and C.1, SP 800-38A ECB, and the all-zero case.
  localparam kat_t KAT_TABLE [4] = '{
    '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
      pt:  128'h3243f6a8885a308d313198a2e0370734,
      ct:  128'h3925841d02dc09fbdc118597196a0b32},
    '{key: 128'h000102030405060708090a0b0c0d0e0f,
      pt:  128'h00112233445566778899aabbccddeeff,
      ct:  128'h69c4e0d86a7b0430d8cdb78070b4c55a},
    '{key: 128'h2b7e151628aed2a6abf7158809cf4f3c,
      pt:  128'h6bc1bee22e409f96e93d7e117393172a,
      ct:  128'h3ad77bb40d7a3660a89ecaf32466ef97},
    '{key: 128'h00000000000000000000000000000000,
      pt:  128'h00000000000000000000000000000000,
      ct:  128'h66e94bd4ef8a2c3b884cfa59ca342b2e}
  };

  logic                 clk;
  logic                 arst_n;
  aes_pkg::aes_wb_req_t wb_req;
  aes_pkg::aes_wb_rsp_t wb_rsp;
  int                   errors;   // Failed checks and timeouts.
  int                   checks;

  aes_core_top UUT (
    .clk    (clk),
    .arst_n (arst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  always #2 clk = ~clk;   // 4 ns period.

  task automatic check(input string name, input logic [127:0] expected,
                       input logic [127:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // One classic cycle, driven on the falling edge and held until the ack.
  task automatic bus_cycle(input logic we, input logic [3:0] adr,
                           input aes_pkg::aes_word_t wdat, output aes_pkg::aes_word_t rdat);
    int n;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_rsp.ack && n < 20);
    rdat = wb_rsp.dat;   // Read data is valid alongside the ack.
    if (!wb_rsp.ack) begin
      errors++;
      $display("ERROR: no ack within 20 cycles for access to word %0d", adr);
    end
    wb_req = '0;   // Request drops in the cycle after the ack.
  endtask

  task automatic wb_write(input logic [3:0] adr, input aes_pkg::aes_word_t dat);
    aes_pkg::aes_word_t ignored;
    bus_cycle(1'b1, adr, dat, ignored);
  endtask

  task automatic wb_read(input logic [3:0] adr, output aes_pkg::aes_word_t dat);
    bus_cycle(1'b0, adr, '0, dat);
  endtask

  // Word 0 carries the most significant 32 bits.
  task automatic write_block(input logic [3:0] base, input aes_pkg::aes_block_t blk);
    for (int i = 0; i < 4; i++) begin
      wb_write(4'(base + i), blk[127 - 32 * i -: 32]);
    end
  endtask

  task automatic read_block(input logic [3:0] base, output aes_pkg::aes_block_t blk);
    aes_pkg::aes_word_t w;
    blk = '0;
    for (int i = 0; i < 4; i++) begin
      wb_read(4'(base + i), w);
      blk[127 - 32 * i -: 32] = w;
    end
  endtask

  // Polls STATUS until the sticky done bit is set.
  task automatic wait_done();
    aes_pkg::aes_word_t status;
    int polls;
    status = '0;
    polls = 0;
    while (!status[1] && polls < 100) begin
      wb_read(aes_pkg::ADR_STATUS, status);
      polls++;
    end
    if (!status[1]) begin
      errors++;
      $display("ERROR: the core did not report done within 100 status polls");
    end
  endtask

  task automatic run_block(input aes_pkg::aes_block_t key, input aes_pkg::aes_block_t din,
                           input logic decrypt, output aes_pkg::aes_block_t dout);
    aes_pkg::aes_word_t status;
    write_block(aes_pkg::ADR_KEY0, key);
    write_block(aes_pkg::ADR_DATA0, din);
    wb_write(aes_pkg::ADR_CTRL, {30'd0, decrypt, 1'b1});
    wait_done();
    read_block(aes_pkg::ADR_RES0, dout);
    wb_read(aes_pkg::ADR_STATUS, status);
    check("STATUS", 128'h2, 128'(status));   // Done set and busy clear.
  endtask

  function automatic aes_pkg::aes_block_t random_block();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  initial begin
    aes_pkg::aes_word_t  word;
    aes_pkg::aes_block_t key;
    aes_pkg::aes_block_t blk;
    aes_pkg::aes_block_t res;
    aes_pkg::aes_block_t back;
    clk    = 1'b0;
    arst_n = 1'b0;
    wb_req = '0;
    errors = 0;
    checks = 0;
    void'($urandom(32'hc8d19fc7));
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Everything reads as zero out of reset.
    wb_read(aes_pkg::ADR_STATUS, word);
    check("STATUS", 128'h0, 128'(word));
    for (int i = 0; i < 4; i++) begin
      wb_read(4'(aes_pkg::ADR_RES0 + i), word);
      check($sformatf("RES%0d", i), 128'h0, 128'(word));
      wb_read(4'(aes_pkg::ADR_KEY0 + i), word);
      check($sformatf("KEY%0d", i), 128'h0, 128'(word));
    end

    // Key and data read back, and writes to RES and STATUS are ignored.
    key = random_block();
    blk = random_block();
    write_block(aes_pkg::ADR_KEY0, key);
    write_block(aes_pkg::ADR_DATA0, blk);
    write_block(aes_pkg::ADR_RES0, {4{32'hffff_ffff}});
    wb_write(aes_pkg::ADR_STATUS, 32'hffff_ffff);
    read_block(aes_pkg::ADR_KEY0, res);
    check("KEY", key, res);
    read_block(aes_pkg::ADR_DATA0, res);
    check("DATA", blk, res);
    read_block(aes_pkg::ADR_RES0, res);
    check("RES", 128'h0, res);
    wb_read(aes_pkg::ADR_STATUS, word);
    check("STATUS", 128'h0, 128'(word));

    // Known answers in both directions.
    for (int r = 0; r < 4; r++) begin
      run_block(KAT_TABLE[r].key, KAT_TABLE[r].pt, 1'b0, res);
      check($sformatf("RES encrypt row %0d", r), KAT_TABLE[r].ct, res);
      run_block(KAT_TABLE[r].key, KAT_TABLE[r].ct, 1'b1, res);
      check($sformatf("RES decrypt row %0d", r), KAT_TABLE[r].pt, res);
    end

    // A decrypt start during an encryption is dropped.
    write_block(aes_pkg::ADR_KEY0, KAT_TABLE[0].key);
    write_block(aes_pkg::ADR_DATA0, KAT_TABLE[0].pt);
    wb_write(aes_pkg::ADR_CTRL, 32'h1);
    wb_read(aes_pkg::ADR_STATUS, word);
    check("STATUS while busy", 128'h1, 128'(word));
    wb_write(aes_pkg::ADR_CTRL, 32'h3);
    wait_done();
    read_block(aes_pkg::ADR_RES0, res);
    check("RES after second start", KAT_TABLE[0].ct, res);
    wb_read(aes_pkg::ADR_STATUS, word);
    check("STATUS after second start", 128'h2, 128'(word));

    // Random blocks must survive an encrypt and decrypt round trip.
    for (int n = 0; n < 20; n++) begin
      key = random_block();
      blk = random_block();
      run_block(key, blk, 1'b0, res);
      run_block(key, res, 1'b1, back);
      check($sformatf("round trip %0d", n), blk, back);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== aes_core_top.f ====
source/aes_pkg.sv
source/aes_key_expand.sv
source/aes_round.sv
source/aes_ctrl.sv
source/aes_wb_regs.sv
source/aes_core_top.sv
dv/aes_core_properties.sv
dv/aes_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the AES core testbench with Verilator, run it and scan the log.
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f aes_core_top.f \
  --top-module aes_core_tb \
  -o aes_core_sim

./obj_dir/aes_core_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
